// ==== rtl/ft_test_pkg.sv ====
package ft_test_pkg;

    // ====================
    // Basic widths
    // ====================

    // One byte as seen on either FIFO
    typedef logic [7:0] ft_byte_t;

    // Payload length field in the low bits of a header
    typedef logic [5:0] ft_len_t;

    // Test selector carried in the START payload
    typedef logic [7:0] ft_test_num_t;

    // ====================
    // Header commands
    // ====================

    // Upper two bits of every header byte
    typedef enum logic [1:0] {
        CMD_TEST_START   = 2'd0,
        CMD_TEST_DATA    = 2'd1,
        CMD_TEST_STOP    = 2'd2,
        CMD_TEST_STOPPED = 2'd3
    } ft_cmd_t;

    // Known tests
    localparam ft_test_num_t TEST_RECEIVE      = 8'd0;
    localparam ft_test_num_t TEST_RECEIVE_SEND = 8'd1;
    localparam ft_test_num_t TEST_SEND         = 8'd2;

    // ====================
    // Status codes
    // ====================

    // First payload byte of a STOPPED frame
    typedef enum logic [7:0] {
        ERR_NONE          = 8'd0,
        ERR_START_PAYLOAD = 8'd1,
        ERR_STOP_PAYLOAD  = 8'd2,
        ERR_TEST_NUM      = 8'd3,
        ERR_TEST_DATA     = 8'd4,
        ERR_CMD           = 8'd5
    } ft_err_t;

endpackage

// ==== rtl/ft_frame_parser.sv ====
`timescale 1ns/100ps

module ft_frame_parser import ft_test_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     empty_i,
    input  logic     writer_busy_i,
    input  ft_byte_t data_i,
    output logic     rd_en_o,
    output logic     report_o,
    output logic     echo_o,
    output logic     send_start_o,
    output logic     err_led_o,
    output ft_len_t  report_len_o,
    output ft_err_t  report_code_o,
    output ft_byte_t report_arg0_o,
    output ft_byte_t report_arg1_o,
    output ft_byte_t echo_byte_o
);

    // Top level states
    typedef enum logic [1:0] {
        ST_WAIT,
        ST_READ,
        ST_HALT
    } parse_state_t;

    // Position inside a frame
    typedef enum logic {
        PH_HEADER,
        PH_PAYLOAD
    } phase_t;

    parse_state_t state_q;
    phase_t       phase_q;
    logic         fetch_q;
    ft_len_t      remain_q;
    ft_cmd_t      last_cmd_q;
    ft_test_num_t test_num_q;
    ft_byte_t     expected_q;

    // Byte decode results
    logic    take;
    ft_cmd_t hdr_cmd;
    ft_len_t hdr_len;
    logic    rep_d;
    logic    echo_d;
    logic    start_d;
    logic    fail_d;
    ft_len_t rep_len_d;
    ft_err_t rep_code_d;

    // Pulse only from read state, never with a byte still pending
    assign rd_en_o = (state_q == ST_READ) && !fetch_q && !empty_i && !writer_busy_i;

    // FIFO data valid one cycle after the pulse
    assign take = (state_q == ST_READ) && fetch_q;

    assign hdr_cmd = ft_cmd_t'(data_i[7:6]);
    assign hdr_len = data_i[5:0];

    // ====================
    // Byte decision
    // ====================
    always_comb begin
        rep_d      = 1'b0;
        echo_d     = 1'b0;
        start_d    = 1'b0;
        fail_d     = 1'b0;
        rep_len_d  = 6'd1;
        rep_code_d = ERR_NONE;
        if (take) begin
            if (phase_q == PH_HEADER) begin
                case (hdr_cmd)
                    CMD_TEST_START: begin
                        // START carries exactly the test number
                        if (hdr_len != 6'd1) begin
                            rep_d      = 1'b1;
                            fail_d     = 1'b1;
                            rep_len_d  = 6'd2;
                            rep_code_d = ERR_START_PAYLOAD;
                        end
                    end
                    CMD_TEST_DATA: begin
                        // Payload checked byte by byte
                    end
                    CMD_TEST_STOP: begin
                        rep_d = 1'b1;
                        if (hdr_len != 6'd0) begin
                            fail_d     = 1'b1;
                            rep_code_d = ERR_STOP_PAYLOAD;
                        end
                    end
                    default: begin
                        // STOPPED only flows the other way
                        rep_d      = 1'b1;
                        fail_d     = 1'b1;
                        rep_code_d = ERR_CMD;
                    end
                endcase
            end else if (last_cmd_q == CMD_TEST_START) begin
                case (data_i)
                    TEST_RECEIVE, TEST_RECEIVE_SEND: begin
                        // Nothing until data arrives
                    end
                    TEST_SEND: begin
                        start_d = 1'b1;
                    end
                    default: begin
                        rep_d      = 1'b1;
                        fail_d     = 1'b1;
                        rep_len_d  = 6'd2;
                        rep_code_d = ERR_TEST_NUM;
                    end
                endcase
            end else if (data_i != expected_q) begin
                // Actual then expected in the arguments
                rep_d      = 1'b1;
                fail_d     = 1'b1;
                rep_len_d  = 6'd3;
                rep_code_d = ERR_TEST_DATA;
            end else if (test_num_q == TEST_RECEIVE_SEND) begin
                echo_d = 1'b1;
            end
        end
    end

    // ====================
    // Control state
    // ====================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q      <= ST_WAIT;
            phase_q      <= PH_HEADER;
            fetch_q      <= 1'b0;
            remain_q     <= '0;
            last_cmd_q   <= CMD_TEST_START;
            test_num_q   <= TEST_RECEIVE;
            expected_q   <= '0;
            report_o     <= 1'b0;
            echo_o       <= 1'b0;
            send_start_o <= 1'b0;
            err_led_o    <= 1'b0;
        end else begin
            // Strobes last one cycle
            report_o     <= rep_d;
            echo_o       <= echo_d;
            send_start_o <= start_d;
            case (state_q)
                ST_WAIT: begin
                    // Hold off until the writer has drained
                    if (!writer_busy_i) begin
                        state_q <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (rd_en_o) begin
                        fetch_q <= 1'b1;
                    end
                    if (take) begin
                        fetch_q <= 1'b0;
                        if (phase_q == PH_HEADER) begin
                            if (hdr_cmd == CMD_TEST_START) begin
                                err_led_o <= 1'b0;
                            end
                            // Zero length frames stay in header phase
                            if (hdr_len != 6'd0 && !fail_d) begin
                                phase_q    <= PH_PAYLOAD;
                                remain_q   <= hdr_len;
                                last_cmd_q <= hdr_cmd;
                            end
                        end else begin
                            remain_q <= remain_q - 6'd1;
                            if (remain_q == 6'd1) begin
                                phase_q <= PH_HEADER;
                            end
                            if (last_cmd_q == CMD_TEST_START) begin
                                test_num_q <= data_i;
                                expected_q <= '0;
                            end else if (!fail_d) begin
                                expected_q <= expected_q + 8'd1;
                            end
                        end
                        // Error wins over the LED clear above
                        if (fail_d) begin
                            err_led_o <= 1'b1;
                            state_q   <= ST_HALT;
                        end else if (rep_d || echo_d || start_d) begin
                            state_q <= ST_WAIT;
                        end
                    end
                end
                default: begin
                    // Halted until reset
                end
            endcase
        end
    end

    // Report and echo payload
    always_ff @(posedge clk) begin
        if (rep_d) begin
            report_len_o  <= rep_len_d;
            report_code_o <= rep_code_d;
            report_arg0_o <= data_i;
            report_arg1_o <= expected_q;
        end
        if (echo_d) begin
            echo_byte_o <= data_i;
        end
    end

endmodule

// ==== rtl/ft_packet_gen.sv ====
`timescale 1ns/100ps

module ft_packet_gen import ft_test_pkg::*; #(
    parameter logic [7:0] PACKETS_COUNT  = 8'd1,
    parameter ft_len_t    PACKET_PAYLOAD = 6'd63
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     start_i,
    input  logic     take_i,
    output logic     active_o,
    output logic     last_o,
    output ft_byte_t byte_o
);

    typedef enum logic {
        GEN_HEADER,
        GEN_PAYLOAD
    } gen_state_t;

    // Final indices of the two counters
    localparam logic [7:0] LAST_PACKET = PACKETS_COUNT - 8'd1;
    localparam ft_len_t    LAST_BYTE   = PACKET_PAYLOAD - 6'd1;

    gen_state_t state_q;
    logic       running_q;
    logic [7:0] packet_q;
    ft_len_t    index_q;
    ft_byte_t   data_q;

    // Active already in the start cycle
    assign active_o = running_q | start_i;

    // Header or running data value
    assign byte_o = (state_q == GEN_HEADER) ? {CMD_TEST_DATA, PACKET_PAYLOAD} : data_q;

    assign last_o = (state_q == GEN_PAYLOAD) && (index_q == LAST_BYTE)
                    && (packet_q == LAST_PACKET);

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q   <= GEN_HEADER;
            running_q <= 1'b0;
            packet_q  <= '0;
            index_q   <= '0;
            data_q    <= '0;
        end else begin
            if (start_i) begin
                running_q <= 1'b1;
            end
            // One step per byte taken by the writer
            if (take_i) begin
                case (state_q)
                    GEN_HEADER: begin
                        state_q <= GEN_PAYLOAD;
                    end
                    default: begin
                        data_q <= data_q + 8'd1;
                        if (index_q == LAST_BYTE) begin
                            index_q <= '0;
                            state_q <= GEN_HEADER;
                            if (packet_q == LAST_PACKET) begin
                                // Back to idle defaults
                                packet_q  <= '0;
                                running_q <= 1'b0;
                                data_q    <= '0;
                            end else begin
                                packet_q <= packet_q + 8'd1;
                            end
                        end else begin
                            index_q <= index_q + 6'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/ft_out_writer.sv ====
`timescale 1ns/100ps

module ft_out_writer import ft_test_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     out_full_i,
    input  logic     out_afull_i,
    input  logic     report_i,
    input  logic     echo_i,
    input  logic     gen_active_i,
    input  logic     gen_last_i,
    input  ft_len_t  report_len_i,
    input  ft_err_t  report_code_i,
    input  ft_byte_t report_arg0_i,
    input  ft_byte_t report_arg1_i,
    input  ft_byte_t echo_byte_i,
    input  ft_byte_t gen_byte_i,
    output logic     wr_en_o,
    output logic     gen_take_o,
    output logic     busy_o,
    output ft_byte_t wr_data_o
);

    // Frame buffer, header first
    ft_byte_t   frame_q [0:3];
    logic [1:0] index_q;
    logic [1:0] last_q;
    logic       frame_valid_q;

    // Flags sampled at the previous edge
    logic ready_q;
    logic use_gen;
    logic gen_done;
    logic load;

    // Generator only when nothing is buffered
    assign use_gen    = gen_active_i && !frame_valid_q;
    assign wr_en_o    = ready_q && (frame_valid_q || gen_active_i);
    assign gen_take_o = ready_q && use_gen;
    assign wr_data_o  = use_gen ? gen_byte_i : frame_q[index_q];

    // Final generator byte leaves in this cycle
    assign gen_done = gen_take_o && gen_last_i;
    assign load     = report_i || echo_i || gen_done;

    assign busy_o = report_i || echo_i || frame_valid_q || gen_active_i;

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            ready_q       <= 1'b0;
            frame_valid_q <= 1'b0;
            index_q       <= '0;
            last_q        <= '0;
        end else begin
            ready_q <= !out_full_i && !out_afull_i;
            // Drain one buffered byte per write
            if (wr_en_o && !use_gen) begin
                if (index_q == last_q) begin
                    frame_valid_q <= 1'b0;
                    index_q       <= '0;
                end else begin
                    index_q <= index_q + 2'd1;
                end
            end
            if (load) begin
                frame_valid_q <= 1'b1;
                index_q       <= '0;
                // Echo and final status carry one byte
                last_q <= report_i ? report_len_i[1:0] : 2'd1;
            end
        end
    end

    // ====================
    // Frame contents
    // ====================
    always_ff @(posedge clk) begin
        if (report_i) begin
            frame_q[0] <= {CMD_TEST_STOPPED, report_len_i};
            frame_q[1] <= report_code_i;
            frame_q[2] <= report_arg0_i;
            frame_q[3] <= report_arg1_i;
        end else if (echo_i) begin
            frame_q[0] <= {CMD_TEST_DATA, 6'd1};
            frame_q[1] <= echo_byte_i;
        end else if (gen_done) begin
            // Send test closes with a clean status
            frame_q[0] <= {CMD_TEST_STOPPED, 6'd1};
            frame_q[1] <= ERR_NONE;
        end
    end

endmodule

// ==== rtl/ft_test_ctrl.sv ====
`timescale 1ns/100ps

module ft_test_ctrl import ft_test_pkg::*; #(
    parameter logic [7:0] PACKETS_COUNT  = 8'd1,
    parameter ft_len_t    PACKET_PAYLOAD = 6'd63
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     in_fifo_empty_i,
    input  ft_byte_t in_fifo_data_i,
    input  logic     out_fifo_full_i,
    input  logic     out_fifo_afull_i,
    output logic     in_fifo_rd_en_o,
    output logic     out_fifo_wr_en_o,
    output ft_byte_t out_fifo_data_o,
    output logic     err_led_o
);

    // Parser to writer
    logic     report;
    ft_len_t  report_len;
    ft_err_t  report_code;
    ft_byte_t report_arg0;
    ft_byte_t report_arg1;
    logic     echo;
    ft_byte_t echo_byte;
    logic     writer_busy;

    // Parser to generator, generator to writer
    logic     send_start;
    logic     gen_active;
    logic     gen_last;
    logic     gen_take;
    ft_byte_t gen_byte;

    // ====================
    // Input side
    // ====================
    ft_frame_parser ft_frame_parser_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .empty_i       (in_fifo_empty_i),
        .writer_busy_i (writer_busy),
        .data_i        (in_fifo_data_i),
        .rd_en_o       (in_fifo_rd_en_o),
        .report_o      (report),
        .echo_o        (echo),
        .send_start_o  (send_start),
        .err_led_o     (err_led_o),
        .report_len_o  (report_len),
        .report_code_o (report_code),
        .report_arg0_o (report_arg0),
        .report_arg1_o (report_arg1),
        .echo_byte_o   (echo_byte)
    );

    // Send test source
    ft_packet_gen #(
        .PACKETS_COUNT  (PACKETS_COUNT),
        .PACKET_PAYLOAD (PACKET_PAYLOAD)
    ) ft_packet_gen_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (send_start),
        .take_i   (gen_take),
        .active_o (gen_active),
        .last_o   (gen_last),
        .byte_o   (gen_byte)
    );

    // ====================
    // Output side
    // ====================
    ft_out_writer ft_out_writer_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .out_full_i    (out_fifo_full_i),
        .out_afull_i   (out_fifo_afull_i),
        .report_i      (report),
        .echo_i        (echo),
        .gen_active_i  (gen_active),
        .gen_last_i    (gen_last),
        .report_len_i  (report_len),
        .report_code_i (report_code),
        .report_arg0_i (report_arg0),
        .report_arg1_i (report_arg1),
        .echo_byte_i   (echo_byte),
        .gen_byte_i    (gen_byte),
        .wr_en_o       (out_fifo_wr_en_o),
        .gen_take_o    (gen_take),
        .busy_o        (writer_busy),
        .wr_data_o     (out_fifo_data_o)
    );

endmodule

// ==== dv/ft_test_cases.svh ====
`ifndef FT_TEST_CASES_SVH
`define FT_TEST_CASES_SVH

// Input bytes in FIFO order, output bytes in write order, final LED
task automatic load_case_table();
    // Receive test with counter data 0 1 2
    add_row("receive", 7,
            {header_byte(CMD_TEST_START, 6'd1), TEST_RECEIVE,
             header_byte(CMD_TEST_DATA, 6'd3), 8'd0, 8'd1, 8'd2,
             header_byte(CMD_TEST_STOP, 6'd0)},
            2, {header_byte(CMD_TEST_STOPPED, 6'd1), ERR_NONE}, 1'b0);
    // Each good byte comes back in its own data frame
    add_row("loop_back", 6,
            {header_byte(CMD_TEST_START, 6'd1), TEST_RECEIVE_SEND,
             header_byte(CMD_TEST_DATA, 6'd2), 8'd0, 8'd1,
             header_byte(CMD_TEST_STOP, 6'd0)},
            6, {header_byte(CMD_TEST_DATA, 6'd1), 8'd0,
                header_byte(CMD_TEST_DATA, 6'd1), 8'd1,
                header_byte(CMD_TEST_STOPPED, 6'd1), ERR_NONE}, 1'b0);
    // Two packets of five, data runs on across packets
    add_row("send", 2,
            {header_byte(CMD_TEST_START, 6'd1), TEST_SEND},
            14, {header_byte(CMD_TEST_DATA, 6'd5), 8'd0, 8'd1, 8'd2, 8'd3, 8'd4,
                 header_byte(CMD_TEST_DATA, 6'd5), 8'd5, 8'd6, 8'd7, 8'd8, 8'd9,
                 header_byte(CMD_TEST_STOPPED, 6'd1), ERR_NONE}, 1'b0);
    // Second byte wrong, trailing bytes ignored
    add_row("wrong_data", 7,
            {header_byte(CMD_TEST_START, 6'd1), TEST_RECEIVE,
             header_byte(CMD_TEST_DATA, 6'd3), 8'd0, 8'h05, 8'd2,
             header_byte(CMD_TEST_STOP, 6'd0)},
            4, {header_byte(CMD_TEST_STOPPED, 6'd3), ERR_TEST_DATA, 8'h05, 8'h01}, 1'b1);
    // Framing errors
    add_row("start_len_2", 3,
            {header_byte(CMD_TEST_START, 6'd2), 8'd0, 8'd0},
            3, {header_byte(CMD_TEST_STOPPED, 6'd2), ERR_START_PAYLOAD,
                header_byte(CMD_TEST_START, 6'd2)}, 1'b1);
    add_row("test_num_7", 2,
            {header_byte(CMD_TEST_START, 6'd1), 8'd7},
            3, {header_byte(CMD_TEST_STOPPED, 6'd2), ERR_TEST_NUM, 8'd7}, 1'b1);
    add_row("stop_len_1", 2,
            {header_byte(CMD_TEST_STOP, 6'd1), 8'd0},
            2, {header_byte(CMD_TEST_STOPPED, 6'd1), ERR_STOP_PAYLOAD}, 1'b1);
    add_row("stopped_hdr", 1,
            {header_byte(CMD_TEST_STOPPED, 6'd0)},
            2, {header_byte(CMD_TEST_STOPPED, 6'd1), ERR_CMD}, 1'b1);
endtask

`endif

// ==== dv/ft_test_tb.sv ====
`timescale 1ns/100ps

module ft_test_tb import ft_test_pkg::*; ();

    localparam int NUM_ROWS     = 8;
    localparam int QUIET_CYCLES = 8;

    // DUT side
    logic     clk;
    logic     reset;
    logic     in_fifo_empty;
    ft_byte_t in_fifo_data;
    logic     out_fifo_full;
    logic     out_fifo_afull;
    logic     in_fifo_rd_en;
    logic     out_fifo_wr_en;
    ft_byte_t out_fifo_data;
    logic     err_led;

    // Case table with bytes right aligned and the first byte highest
    string        case_name    [NUM_ROWS];
    int           case_in_len  [NUM_ROWS];
    logic [63:0]  case_in      [NUM_ROWS];
    int           case_out_len [NUM_ROWS];
    logic [127:0] case_out     [NUM_ROWS];
    logic         case_led     [NUM_ROWS];
    int           case_count = 0;

    // FIFO models and frame tracking
    ft_byte_t    in_q [$];
    ft_byte_t    out_q [$];
    ft_len_t     frame_left;
    logic        in_status;
    logic        status_done;
    logic        wr_blocked;
    logic [31:0] rand_state = 32'hb6eb_a0e2;

    // Run bookkeeping
    int row_errors  = 0;
    int pass_rows   = 0;
    int fail_rows   = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    ft_test_ctrl #(
        .PACKETS_COUNT  (8'd2),
        .PACKET_PAYLOAD (6'd5)
    ) ft_test_ctrl_inst (
        .clk              (clk),
        .reset_i          (reset),
        .in_fifo_empty_i  (in_fifo_empty),
        .in_fifo_data_i   (in_fifo_data),
        .out_fifo_full_i  (out_fifo_full),
        .out_fifo_afull_i (out_fifo_afull),
        .in_fifo_rd_en_o  (in_fifo_rd_en),
        .out_fifo_wr_en_o (out_fifo_wr_en),
        .out_fifo_data_o  (out_fifo_data),
        .err_led_o        (err_led)
    );

    always #50 clk = ~clk;

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Header byte from its two fields
    function automatic ft_byte_t header_byte(input ft_cmd_t cmd, input ft_len_t len);
        return {cmd, len};
    endfunction

    task automatic add_row(input string name, input int n_in, input logic [63:0] in_v,
                           input int n_out, input logic [127:0] out_v, input logic led);
        case_name[case_count]    = name;
        case_in_len[case_count]  = n_in;
        case_in[case_count]      = in_v;
        case_out_len[case_count] = n_out;
        case_out[case_count]     = out_v;
        case_led[case_count]     = led;
        case_count++;
    endtask

    task automatic compare_byte(input string name, input ft_byte_t actual,
                                input ft_byte_t expected);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %02h actual %02h", $time, name, expected, actual);
            row_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
            row_errors++;
        end
    endtask

    `include "ft_test_cases.svh"

    // ====================
    // FIFO models
    // ====================

    // Pop on the read pulse so the byte is valid in the next cycle
    always @(posedge clk) begin
        if (in_fifo_rd_en && in_fifo_empty) begin
            $display("Read pulse at %0t while the input FIFO was empty", $time);
            row_errors++;
        end
        if (in_fifo_rd_en && in_q.size() > 0) begin
            in_fifo_data <= in_q.pop_front();
        end
        in_fifo_empty <= (in_q.size() == 0);
        // Almost full about one cycle in four
        rand_state = xorshift32(rand_state);
        out_fifo_afull <= (rand_state[1:0] == 2'b00);
    end

    // Capture writes and follow frame boundaries
    always @(posedge clk) begin
        // Flags as the DUT saw them at this edge
        wr_blocked <= out_fifo_full || out_fifo_afull;
        if (reset) begin
            frame_left  <= '0;
            in_status   <= 1'b0;
            status_done <= 1'b0;
        end else if (out_fifo_wr_en) begin
            if (wr_blocked) begin
                $display("Write at %0t although the output FIFO was full or almost full",
                         $time);
                row_errors++;
            end
            out_q.push_back(out_fifo_data);
            if (frame_left == 6'd0) begin
                // Header opens a new frame
                frame_left <= out_fifo_data[5:0];
                in_status  <= (ft_cmd_t'(out_fifo_data[7:6]) == CMD_TEST_STOPPED);
                if (ft_cmd_t'(out_fifo_data[7:6]) == CMD_TEST_STOPPED
                    && out_fifo_data[5:0] == 6'd0) begin
                    status_done <= 1'b1;
                end
            end else begin
                frame_left <= frame_left - 6'd1;
                if (frame_left == 6'd1 && in_status) begin
                    status_done <= 1'b1;
                end
            end
        end
    end

    // Overall cycle limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ====================
    // One table row
    // ====================
    task automatic run_row(input int r);
        int       waited;
        int       n;
        int       i;
        ft_byte_t exp_byte;
        row_errors = 0;
        @(posedge clk);
        reset <= 1'b1;
        in_q.delete();
        out_q.delete();
        for (i = 0; i < case_in_len[r]; i++) begin
            in_q.push_back(case_in[r][(case_in_len[r] - 1 - i) * 8 +: 8]);
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Wait for the closing status frame
        waited = 0;
        while (!status_done && waited < 12 + 4 * (case_in_len[r] + case_out_len[r])) begin
            @(posedge clk);
            waited++;
        end
        if (!status_done) begin
            $display("row %0d %s: no complete status frame after %0d cycles",
                     r, case_name[r], waited);
            row_errors++;
        end
        // Nothing more may follow the status
        repeat (QUIET_CYCLES) @(posedge clk);
        if (out_q.size() != case_out_len[r]) begin
            $display("row %0d %s: captured %0d output bytes where %0d were expected",
                     r, case_name[r], out_q.size(), case_out_len[r]);
            row_errors++;
        end
        n = (out_q.size() < case_out_len[r]) ? out_q.size() : case_out_len[r];
        for (i = 0; i < n; i++) begin
            exp_byte = case_out[r][(case_out_len[r] - 1 - i) * 8 +: 8];
            compare_byte($sformatf("out_fifo_data[%0d]", i), out_q[i], exp_byte);
        end
        compare_flag("err_led", err_led, case_led[r]);
        if (row_errors == 0) begin
            pass_rows++;
            $display("row %0d %s: passed", r, case_name[r]);
        end else begin
            fail_rows++;
            $display("row %0d %s: failed with %0d errors", r, case_name[r], row_errors);
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_fifo_empty  = 1'b1;
        in_fifo_data   = '0;
        out_fifo_full  = 1'b0;
        out_fifo_afull = 1'b0;
        load_case_table();
        // Limit from the length of every row
        cycle_limit = 16;
        for (int r = 0; r < case_count; r++) begin
            cycle_limit += 40 + 4 * (case_in_len[r] + case_out_len[r]);
        end
        for (int r = 0; r < case_count; r++) begin
            run_row(r);
        end
        $display("rows passed %0d failed %0d", pass_rows, fail_rows);
        if (fail_rows == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+dv
rtl/ft_test_pkg.sv
rtl/ft_frame_parser.sv
rtl/ft_packet_gen.sv
rtl/ft_out_writer.sv
rtl/ft_test_ctrl.sv
dv/ft_test_tb.sv
